// File: filelist.f
+incdir+common
common/cpu_pkg.sv
datapath/cpu_alu.sv
datapath/cpu_regfile.sv
control/cpu_decoder.sv
control/cpu_sequencer.sv
rtl/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu.sv

// File: tb/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          NROWS  = 20;
    localparam logic [15:0] POISON = 16'h00F0;    // JMP must skip the store here

    // Row operations
    localparam logic [3:0] OP_ORA = 4'd0, OP_AND = 4'd1, OP_EOR = 4'd2, OP_ADC = 4'd3;
    localparam logic [3:0] OP_SBC = 4'd4, OP_CMP = 4'd5, OP_XINC = 4'd6, OP_YDEC = 4'd7;
    localparam logic [3:0] OP_MEMLD = 4'd8, OP_BR = 4'd9, OP_BRX = 4'd10;

    typedef struct packed {
        logic [3:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic       cin;
        logic [1:0] fill;       // Bit 1 random a, bit 0 random b
    } row_t;

    logic        CLK;
    logic        RESET;
    logic [15:0] addr;
    logic [7:0]  din;
    logic [7:0]  dout;
    logic        wreq;
    logic        done;
    logic        timed_out;
    int          errors;
    int          writes_seen;
    logic [7:0]  mem [0:65535];
    row_t        rows [NROWS];
    logic [15:0] pc_b;          // Program build pointer
    integer      seed;
    logic [7:0]  alu_opc [6] = '{8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hC9}; // Immediate forms

    cpu_top dut (
        .CLK(CLK), .RESET(RESET), .ADDR(addr), .DIN(din), .DOUT(dout), .WREQ(wreq)
    );

    cpu_checker chk (
        .CLK(CLK), .RESET(RESET), .addr(addr), .dout(dout), .wreq(wreq),
        .poison_addr(POISON), .cycle_limit(NROWS * 24 + 50),
        .done(done), .timed_out(timed_out), .errors(errors), .writes_seen(writes_seen)
    );

    // ------------------------------------------------------------
    // Clock and memory
    // ------------------------------------------------------------
    always #5 CLK = ~CLK;

    assign din = mem[addr];                     // Combinational read
    always @(posedge CLK) begin
        if (wreq)
            mem[addr] <= dout;
    end

    task automatic emit(input logic [7:0] b);
        mem[pc_b] = b;
        pc_b      = pc_b + 16'd1;
    endtask

    // Expected result and carry from the instruction rules
    task automatic predict(input row_t r, output logic [7:0] res, output logic c);
        int diff;
        res = r.a;
        c   = r.cin;
        case (r.op)
            OP_ORA:  res = r.a | r.b;
            OP_AND:  res = r.a & r.b;
            OP_EOR:  res = r.a ^ r.b;
            OP_ADC:  {c, res} = r.a + r.b + r.cin;
            OP_SBC, OP_CMP: begin
                diff = int'(r.a) - int'(r.b) - ((r.op == OP_SBC) ? int'(!r.cin) : 0);
                c    = (diff >= 0);             // No borrow
                if (r.op == OP_SBC)
                    res = diff[7:0];
            end
            OP_XINC: res = r.a + 8'd1;
            OP_YDEC: res = r.a - 8'd1;
            default: ;
        endcase
    endtask

    // Flags after LDA #a and CLC/SEC, V is clear
    function automatic logic branch_expected(input logic [7:0] opc, input logic [7:0] a,
                                             input logic c);
        case (opc)
            8'h10:   return !a[7];              // BPL
            8'h30:   return a[7];               // BMI
            8'h50:   return 1'b1;               // BVC
            8'h70:   return 1'b0;               // BVS
            8'h90:   return !c;                 // BCC
            8'hB0:   return c;                  // BCS
            8'hD0:   return a != 8'h00;         // BNE
            default: return a == 8'h00;         // BEQ
        endcase
    endfunction

    // ------------------------------------------------------------
    // One program segment per table row
    // ------------------------------------------------------------
    task automatic build_segment(input int i);
        row_t        r;
        logic [7:0]  res;
        logic [7:0]  slot;
        logic [7:0]  bop;
        logic [15:0] tgt;
        logic        c;
        r = rows[i];
        if (r.fill[1]) r.a = $random(seed);
        if (r.fill[0]) r.b = $random(seed);
        predict(r, res, c);
        slot = 8'h10 + 8'(i * 4);
        if (r.op == OP_BRX) begin               // Jump so the branch crosses a page
            tgt = {pc_b[15:8] + 8'd1, 8'hFA};
            emit(8'h4C); emit(tgt[7:0]); emit(tgt[15:8]);
            emit(8'h8D); emit(POISON[7:0]); emit(POISON[15:8]);
            pc_b = tgt;
        end
        emit(8'hA9); emit(r.a);
        emit(r.cin ? 8'h38 : 8'h18);
        case (r.op)
            OP_XINC: begin                      // TAX INX STX zp
                emit(8'hAA); emit(8'hE8); emit(8'h86); emit(slot);
                chk.expect_write({8'h00, slot}, res);
            end
            OP_YDEC: begin                      // TAY DEY TYA STA abs
                emit(8'hA8); emit(8'h88); emit(8'h98); emit(8'h8D); emit(8'(i)); emit(8'h02);
                chk.expect_write({8'h02, 8'(i)}, res);
            end
            OP_MEMLD: begin
                mem[16'h0080 + i] = r.b;
                mem[16'h0300 + i] = ~r.b;
                emit(8'hA6); emit(8'h80 + 8'(i)); emit(8'h8E); emit(8'(i)); emit(8'h02);
                chk.expect_write({8'h02, 8'(i)}, r.b);
                emit(8'hAC); emit(8'(i)); emit(8'h03); emit(8'h84); emit(slot);
                chk.expect_write({8'h00, slot}, ~r.b);
                emit(8'hAD); emit(8'(i)); emit(8'h03); emit(8'h8D); emit(8'h80 + 8'(i));
                emit(8'h02);
                chk.expect_write({8'h02, 8'h80 + 8'(i)}, ~r.b);
            end
            OP_BR, OP_BRX: begin                // Marker store only when not taken
                bop = {r.b[2:0], 5'b10000};
                emit(bop); emit(8'h02); emit(8'h85); emit(slot);
                if (!branch_expected(bop, r.a, r.cin))
                    chk.expect_write({8'h00, slot}, r.a);
            end
            default: begin
                emit(alu_opc[r.op]); emit(r.b); emit(8'h85); emit(slot);
                chk.expect_write({8'h00, slot}, res);
            end
        endcase
        emit(8'hA9); emit(8'h00); emit(8'h69); emit(8'h00); // A = C
        emit(8'h85); emit(slot + 8'd1);
        chk.expect_write({8'h00, slot + 8'd1}, {7'b0, c});
    endtask

    initial begin
        logic [15:0] self_pc;
        CLK   = 1'b0;
        RESET = 1'b1;
        seed  = 32'h4ad9f1ca;
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        rows[0]  = {OP_ORA,   8'h5A, 8'h0F, 1'b0, 2'b00};
        rows[1]  = {OP_AND,   8'h00, 8'h00, 1'b1, 2'b11};
        rows[2]  = {OP_EOR,   8'hC3, 8'hFF, 1'b0, 2'b00};
        rows[3]  = {OP_ADC,   8'h7F, 8'h01, 1'b0, 2'b00}; // Signed overflow
        rows[4]  = {OP_ADC,   8'hFF, 8'h01, 1'b1, 2'b00};
        rows[5]  = {OP_SBC,   8'h50, 8'h30, 1'b1, 2'b00};
        rows[6]  = {OP_SBC,   8'h10, 8'h20, 1'b1, 2'b00}; // Borrow
        rows[7]  = {OP_SBC,   8'h00, 8'h00, 1'b0, 2'b11};
        rows[8]  = {OP_CMP,   8'h40, 8'h40, 1'b0, 2'b00};
        rows[9]  = {OP_CMP,   8'h10, 8'h20, 1'b1, 2'b00};
        rows[10] = {OP_XINC,  8'hFF, 8'h00, 1'b0, 2'b00}; // FF wraps to 00
        rows[11] = {OP_YDEC,  8'h00, 8'h00, 1'b1, 2'b00}; // 00 wraps to FF
        rows[12] = {OP_MEMLD, 8'h00, 8'h00, 1'b0, 2'b01};
        rows[13] = {OP_BR,    8'h80, 8'h01, 1'b0, 2'b00}; // BMI
        rows[14] = {OP_BR,    8'h00, 8'h06, 1'b0, 2'b00}; // BNE
        rows[15] = {OP_BR,    8'h05, 8'h04, 1'b1, 2'b00}; // BCC
        rows[16] = {OP_BR,    8'h01, 8'h02, 1'b0, 2'b00}; // BVC
        rows[17] = {OP_BR,    8'h7F, 8'h03, 1'b1, 2'b00}; // BVS
        rows[18] = {OP_BRX,   8'h01, 8'h05, 1'b1, 2'b00}; // BCS across a page
        rows[19] = {OP_BRX,   8'h00, 8'h07, 1'b0, 2'b00}; // BEQ across a page
        mem[16'hFFFC] = 8'h00;
        mem[16'hFFFD] = 8'h04;
        pc_b = 16'h0400;
        for (int i = 0; i < NROWS; i++)
            build_segment(i);
        self_pc = pc_b;                         // Park in a JMP to itself
        emit(8'h4C); emit(self_pc[7:0]); emit(self_pc[15:8]);
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        wait (done || timed_out);
        if (!timed_out)
            repeat (8) @(posedge CLK);          // Quiet window for stray writes
        $display("Writes seen: %0d, errors: %0d", writes_seen, errors);
        if (errors == 0 && !timed_out)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/cpu_checker.sv
module cpu_checker (
    input  logic        CLK,
    input  logic        RESET,
    input  logic [15:0] addr,
    input  logic [7:0]  dout,
    input  logic        wreq,
    input  logic [15:0] poison_addr,
    input  int          cycle_limit,
    output logic        done,
    output logic        timed_out,
    output int          errors,
    output int          writes_seen
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] exp_addr [$];  // Expected writes in order
    logic [7:0]  exp_data [$];
    int          cycles;

    task automatic expect_write(input logic [15:0] a, input logic [7:0] d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    initial begin
        done        = 1'b0;
        timed_out   = 1'b0;
        errors      = 0;
        writes_seen = 0;
        cycles      = 0;
    end

    // ------------------------------------------------------------
    // Bus write compare
    // ------------------------------------------------------------
    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (!RESET && wreq) begin
            if (addr == poison_addr) begin
                errors++;
                $display("Write to the poison address %h at %0t, the JMP did not skip it",
                         addr, $time);
            end else if (writes_seen >= exp_addr.size()) begin
                errors++;
                $display("Unexpected extra write of %h to %h at %0t", dout, addr, $time);
            end else if (addr !== exp_addr[writes_seen] || dout !== exp_data[writes_seen]) begin
                errors++;
                $display("Mismatch at %0t: write %0d went to %h with %h, expected %h with %h",
                         $time, writes_seen, addr, dout,
                         exp_addr[writes_seen], exp_data[writes_seen]);
            end
            writes_seen++;
        end
        done = (exp_addr.size() > 0) && (writes_seen >= exp_addr.size());
        if (!timed_out && !done && cycles >= cycle_limit) begin
            timed_out = 1'b1;                   // Missing writes end the run
            errors++;
            $display("Timeout after %0d cycles, only %0d of %0d expected writes appeared",
                     cycles, writes_seen, exp_addr.size());
        end
    end

endmodule

// File: rtl/cpu_top.sv
`include "cpu_defines.svh"

module cpu_top (
    input  logic               CLK,
    input  logic               RESET,
    output logic [`CPU_AW-1:0] ADDR,
    input  logic [`CPU_DW-1:0] DIN,
    output logic [`CPU_DW-1:0] DOUT,
    output logic               WREQ
);

    logic [7:0]          opcode;        // Current opcode
    logic                exec;          // Commit cycle
    cpu_pkg::addr_mode_t mode;
    logic                is_store;
    logic                branch_taken;
    cpu_pkg::reg_sel_t   store_sel;
    cpu_pkg::reg_sel_t   op_a_sel;
    cpu_pkg::reg_sel_t   op_b_sel;
    cpu_pkg::reg_sel_t   dst_sel;
    cpu_pkg::alu_op_t    alu_op;
    logic                reg_we;
    logic                flag_we;
    logic [`CPU_DW-1:0]  op_a;
    logic [`CPU_DW-1:0]  op_b;
    logic [`CPU_DW-1:0]  flags;         // P register
    logic [`CPU_DW-1:0]  store_data;
    logic [`CPU_DW-1:0]  result;
    logic [`CPU_DW-1:0]  next_flags;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    cpu_sequencer u_sequencer (
        .CLK(CLK), .RESET(RESET), .DIN(DIN),
        .ADDR(ADDR), .DOUT(DOUT), .WREQ(WREQ),
        .opcode(opcode), .exec(exec),
        .mode(mode), .is_store(is_store), .branch_taken(branch_taken),
        .store_data(store_data)
    );

    cpu_decoder u_decoder (
        .opcode(opcode), .exec(exec), .flags(flags),
        .mode(mode), .is_store(is_store), .store_sel(store_sel),
        .alu_op(alu_op), .op_a_sel(op_a_sel), .op_b_sel(op_b_sel),
        .dst_sel(dst_sel), .reg_we(reg_we), .flag_we(flag_we),
        .branch_taken(branch_taken)
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    cpu_regfile u_regfile (
        .CLK(CLK), .RESET(RESET), .DIN(DIN),
        .op_a_sel(op_a_sel), .op_b_sel(op_b_sel),
        .dst_sel(dst_sel), .store_sel(store_sel),
        .reg_we(reg_we), .flag_we(flag_we),
        .result(result), .next_flags(next_flags),
        .op_a(op_a), .op_b(op_b), .flags(flags), .store_data(store_data)
    );

    cpu_alu u_alu (
        .op(alu_op), .op_a(op_a), .op_b(op_b), .flags_in(flags),
        .opcode_bit5(opcode[5]),   // Picks CLC or SEC
        .result(result), .next_flags(next_flags)
    );

endmodule

// File: control/cpu_sequencer.sv
`include "cpu_defines.svh"

module cpu_sequencer (
    input  logic                CLK,
    input  logic                RESET,
    input  logic [`CPU_DW-1:0]  DIN,
    output logic [`CPU_AW-1:0]  ADDR,
    output logic [`CPU_DW-1:0]  DOUT,
    output logic                WREQ,
    output logic [7:0]          opcode,
    output logic                exec,
    input  cpu_pkg::addr_mode_t mode,
    input  logic                is_store,
    input  logic                branch_taken,
    input  logic [`CPU_DW-1:0]  store_data
);

    cpu_pkg::micro_state_t state;
    logic [`CPU_AW-1:0]    pc;
    logic [`CPU_AW-1:0]    ea;          // Operand address
    logic [`CPU_DW-1:0]    tmp;         // Low byte of a 16-bit fetch
    logic [7:0]            opcode_q;
    logic                  addr_sel;    // 1 puts EA on the bus

    logic [`CPU_AW-1:0]    pc_inc;
    logic [`CPU_AW-1:0]    pc_rel;      // Branch target

    assign pc_inc = pc + 1'b1;
    assign pc_rel = pc_inc + {{(`CPU_AW-`CPU_DW){DIN[`CPU_DW-1]}}, DIN}; // Signed offset

    // Decoder sees the new opcode while it is still on the bus
    assign opcode = (state == cpu_pkg::FETCH) ? DIN : opcode_q;
    assign exec   = (state == cpu_pkg::EXEC);

    // ------------------------------------------------------------
    // Memory bus
    // ------------------------------------------------------------
    assign ADDR = addr_sel ? ea : pc;
    assign DOUT = store_data;           // Register picked by store_sel
    assign WREQ = exec && is_store;     // One cycle, ADDR = EA

    // ------------------------------------------------------------
    // Micro-state machine
    // ------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= cpu_pkg::RST_LO;
            addr_sel <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::FETCH: begin
                    opcode_q <= DIN;
                    pc       <= pc_inc;
                    case (mode)
                        cpu_pkg::ZERO_PAGE: state <= cpu_pkg::ZP;
                        cpu_pkg::ABSOLUTE,
                        cpu_pkg::JUMP:      state <= cpu_pkg::ABS_LO;
                        cpu_pkg::RELATIVE:  state <= cpu_pkg::REL;
                        default:            state <= cpu_pkg::EXEC; // Implied, immediate
                    endcase
                end
                cpu_pkg::ZP: begin
                    ea       <= {{(`CPU_AW-`CPU_DW){1'b0}}, DIN}; // Page 0
                    pc       <= pc_inc;
                    addr_sel <= 1'b1;
                    state    <= cpu_pkg::EXEC;
                end
                cpu_pkg::ABS_LO: begin
                    tmp   <= DIN;
                    pc    <= pc_inc;
                    state <= cpu_pkg::ABS_HI;
                end
                cpu_pkg::ABS_HI: begin
                    if (mode == cpu_pkg::JUMP) begin
                        pc    <= {DIN, tmp};        // JMP done here
                        state <= cpu_pkg::FETCH;
                    end else begin
                        ea       <= {DIN, tmp};
                        pc       <= pc_inc;
                        addr_sel <= 1'b1;
                        state    <= cpu_pkg::EXEC;
                    end
                end
                cpu_pkg::EXEC: begin
                    if (mode == cpu_pkg::IMMEDIATE)
                        pc <= pc_inc;               // Step past operand
                    addr_sel <= 1'b0;
                    state    <= cpu_pkg::FETCH;
                end
                cpu_pkg::REL: begin
                    if (branch_taken) begin
                        pc    <= pc_rel;
                        // Same page check against the next instruction's address
                        state <= (pc_rel[`CPU_AW-1:`CPU_DW] == pc_inc[`CPU_AW-1:`CPU_DW]) ?
                                 cpu_pkg::REL_DONE : cpu_pkg::REL_PAGE;
                    end else begin
                        pc    <= pc_inc;
                        state <= cpu_pkg::FETCH;
                    end
                end
                cpu_pkg::REL_PAGE: state <= cpu_pkg::REL_DONE; // Page cross
                cpu_pkg::REL_DONE: state <= cpu_pkg::FETCH;
                cpu_pkg::RST_LO: begin
                    pc    <= `CPU_RESET_VECTOR;
                    state <= cpu_pkg::RST_HI;
                end
                cpu_pkg::RST_HI: begin
                    tmp   <= DIN;                   // Vector low
                    pc    <= pc_inc;
                    state <= cpu_pkg::RST_JMP;
                end
                cpu_pkg::RST_JMP: begin
                    pc    <= {DIN, tmp};
                    state <= cpu_pkg::FETCH;
                end
                default: state <= cpu_pkg::RST_LO;  // Unreached codes restart
            endcase
        end
    end

endmodule

// File: control/cpu_decoder.sv
`include "cpu_defines.svh"

module cpu_decoder (
    input  logic [7:0]          opcode,
    input  logic                exec,
    input  logic [`CPU_DW-1:0]  flags,
    output cpu_pkg::addr_mode_t mode,
    output logic                is_store,
    output cpu_pkg::reg_sel_t   store_sel,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::reg_sel_t   op_a_sel,
    output cpu_pkg::reg_sel_t   op_b_sel,
    output cpu_pkg::reg_sel_t   dst_sel,
    output logic                reg_we,
    output logic                flag_we,
    output logic                branch_taken
);

    cpu_pkg::addr_mode_t mem_mode;  // From bbb, shared by all groups
    logic                wr;        // Register write, before exec
    logic                fw;        // Flag write, before exec
    logic                cond_flag;

    assign mem_mode = !opcode[2] ? cpu_pkg::IMMEDIATE :
                      (opcode[3] ? cpu_pkg::ABSOLUTE : cpu_pkg::ZERO_PAGE);

    // ------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------
    always_comb begin
        mode      = cpu_pkg::IMPLIED;
        is_store  = 1'b0;
        store_sel = cpu_pkg::A;
        alu_op    = cpu_pkg::PASS;
        op_a_sel  = cpu_pkg::A;
        op_b_sel  = cpu_pkg::MEM;
        dst_sel   = cpu_pkg::A;
        wr        = 1'b0;
        fw        = 1'b0;
        casez (opcode)
            8'h89: mode = cpu_pkg::IMPLIED;             // No STA immediate
            8'b???_001_01, 8'b???_010_01, 8'b???_011_01: begin
                mode = mem_mode;
                case (opcode[7:5])                      // aaa picks the operation
                    3'b000:  alu_op = cpu_pkg::ORA;
                    3'b001:  alu_op = cpu_pkg::AND;
                    3'b010:  alu_op = cpu_pkg::EOR;
                    3'b011:  alu_op = cpu_pkg::ADC;
                    3'b100:  is_store = 1'b1;           // STA
                    3'b110:  alu_op = cpu_pkg::CMP;
                    3'b111:  alu_op = cpu_pkg::SBC;
                    default: alu_op = cpu_pkg::PASS;    // LDA
                endcase
                wr = (opcode[7:5] != 3'b100) && (opcode[7:5] != 3'b110);
                fw = (opcode[7:5] != 3'b100);
            end
            8'hA2, 8'b101_0?1_10: {mode, dst_sel, wr, fw} = {mem_mode, cpu_pkg::X, 2'b11};
            8'hA0, 8'b101_0?1_00: {mode, dst_sel, wr, fw} = {mem_mode, cpu_pkg::Y, 2'b11};
            8'b100_0?1_10: {mode, is_store, store_sel} = {mem_mode, 1'b1, cpu_pkg::X};
            8'b100_0?1_00: {mode, is_store, store_sel} = {mem_mode, 1'b1, cpu_pkg::Y};
            8'hAA: {op_b_sel, dst_sel, wr, fw} = {cpu_pkg::A, cpu_pkg::X, 2'b11}; // TAX
            8'hA8: {op_b_sel, dst_sel, wr, fw} = {cpu_pkg::A, cpu_pkg::Y, 2'b11}; // TAY
            8'h8A: {op_b_sel, dst_sel, wr, fw} = {cpu_pkg::X, cpu_pkg::A, 2'b11}; // TXA
            8'h98: {op_b_sel, dst_sel, wr, fw} = {cpu_pkg::Y, cpu_pkg::A, 2'b11}; // TYA
            8'hE8: {alu_op, op_a_sel, dst_sel, wr, fw} =
                       {cpu_pkg::INC, cpu_pkg::X, cpu_pkg::X, 2'b11};             // INX
            8'hC8: {alu_op, op_a_sel, dst_sel, wr, fw} =
                       {cpu_pkg::INC, cpu_pkg::Y, cpu_pkg::Y, 2'b11};             // INY
            8'hCA: {alu_op, op_a_sel, dst_sel, wr, fw} =
                       {cpu_pkg::DEC, cpu_pkg::X, cpu_pkg::X, 2'b11};             // DEX
            8'h88: {alu_op, op_a_sel, dst_sel, wr, fw} =
                       {cpu_pkg::DEC, cpu_pkg::Y, cpu_pkg::Y, 2'b11};             // DEY
            8'b00?_110_00: {alu_op, fw} = {cpu_pkg::FLAG_SET_CLEAR, 1'b1};      // CLC, SEC
            8'h4C:         mode = cpu_pkg::JUMP;
            8'b???_100_00: mode = cpu_pkg::RELATIVE;    // Bcc
            default:       mode = cpu_pkg::IMPLIED;     // Two-cycle NOP
        endcase
    end

    assign reg_we  = wr && exec;
    assign flag_we = fw && exec;

    // ------------------------------------------------------------
    // Branch condition
    // ------------------------------------------------------------
    always_comb begin
        case (opcode[7:6])
            2'b00:   cond_flag = flags[`CPU_FLAG_N];  // BPL, BMI
            2'b01:   cond_flag = flags[`CPU_FLAG_V];  // BVC, BVS
            2'b10:   cond_flag = flags[`CPU_FLAG_C];  // BCC, BCS
            default: cond_flag = flags[`CPU_FLAG_Z];  // BNE, BEQ
        endcase
    end

    assign branch_taken = (cond_flag == opcode[5]);   // Bit 5 is the wanted value

endmodule

// File: datapath/cpu_regfile.sv
`include "cpu_defines.svh"

module cpu_regfile (
    input  logic               CLK,
    input  logic               RESET,
    input  logic [`CPU_DW-1:0] DIN,
    input  cpu_pkg::reg_sel_t  op_a_sel,
    input  cpu_pkg::reg_sel_t  op_b_sel,
    input  cpu_pkg::reg_sel_t  dst_sel,
    input  cpu_pkg::reg_sel_t  store_sel,
    input  logic               reg_we,
    input  logic               flag_we,
    input  logic [`CPU_DW-1:0] result,
    input  logic [`CPU_DW-1:0] next_flags,
    output logic [`CPU_DW-1:0] op_a,
    output logic [`CPU_DW-1:0] op_b,
    output logic [`CPU_DW-1:0] flags,
    output logic [`CPU_DW-1:0] store_data
);

    logic [`CPU_DW-1:0] acc;    // A
    logic [`CPU_DW-1:0] x_reg;
    logic [`CPU_DW-1:0] y_reg;
    logic [`CPU_DW-1:0] p_reg;  // NV--DIZC

    function automatic logic [`CPU_DW-1:0] pick(
        input cpu_pkg::reg_sel_t  sel,
        input logic [`CPU_DW-1:0] a,
        input logic [`CPU_DW-1:0] x,
        input logic [`CPU_DW-1:0] y,
        input logic [`CPU_DW-1:0] mem
    );
        case (sel)
            cpu_pkg::A: return a;
            cpu_pkg::X: return x;
            cpu_pkg::Y: return y;
            default:    return mem;     // Bus data
        endcase
    endfunction

    // ------------------------------------------------------------
    // Operand and store muxes
    // ------------------------------------------------------------
    assign op_a       = pick(op_a_sel, acc, x_reg, y_reg, DIN);
    assign op_b       = pick(op_b_sel, acc, x_reg, y_reg, DIN);
    assign store_data = pick(store_sel, acc, x_reg, y_reg, DIN);
    assign flags      = p_reg;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            acc   <= '0;
            x_reg <= '0;
            y_reg <= '0;
            p_reg <= '0;
        end else begin
            if (reg_we) begin
                case (dst_sel)
                    cpu_pkg::A: acc   <= result;
                    cpu_pkg::X: x_reg <= result;
                    cpu_pkg::Y: y_reg <= result;
                    default:    acc   <= acc;   // MEM is not a target
                endcase
            end
            if (flag_we)
                p_reg <= next_flags;
        end
    end

endmodule

// File: datapath/cpu_alu.sv
`include "cpu_defines.svh"

module cpu_alu (
    input  cpu_pkg::alu_op_t   op,
    input  logic [`CPU_DW-1:0] op_a,
    input  logic [`CPU_DW-1:0] op_b,
    input  logic [`CPU_DW-1:0] flags_in,
    input  logic               opcode_bit5,
    output logic [`CPU_DW-1:0] result,
    output logic [`CPU_DW-1:0] next_flags
);

    logic               subtract;   // SBC, CMP
    logic [`CPU_DW-1:0] b_eff;      // Inverted on subtract
    logic               carry_in;
    logic [`CPU_DW:0]   sum;        // Carry out on top

    assign subtract = (op == cpu_pkg::SBC) || (op == cpu_pkg::CMP);
    assign b_eff    = subtract ? ~op_b : op_b;
    assign carry_in = (op == cpu_pkg::CMP) ? 1'b1 : flags_in[`CPU_FLAG_C]; // CMP ignores C
    assign sum      = op_a + b_eff + carry_in;

    // ------------------------------------------------------------
    // Result and flags
    // ------------------------------------------------------------
    always_comb begin
        result     = op_b;
        next_flags = flags_in;
        case (op)
            cpu_pkg::ORA: result = op_a | op_b;
            cpu_pkg::AND: result = op_a & op_b;
            cpu_pkg::EOR: result = op_a ^ op_b;
            cpu_pkg::ADC, cpu_pkg::SBC: begin
                result                 = sum[`CPU_DW-1:0];
                next_flags[`CPU_FLAG_C] = sum[`CPU_DW];
                // Same-sign inputs, result sign differs
                next_flags[`CPU_FLAG_V] = (op_a[`CPU_DW-1] == b_eff[`CPU_DW-1]) &&
                                          (sum[`CPU_DW-1] != op_a[`CPU_DW-1]);
            end
            cpu_pkg::CMP: begin
                result                 = sum[`CPU_DW-1:0];  // Flags only
                next_flags[`CPU_FLAG_C] = sum[`CPU_DW];      // Set when A >= M
            end
            cpu_pkg::INC: result = op_a + 1'b1;             // FF wraps to 00
            cpu_pkg::DEC: result = op_a - 1'b1;
            cpu_pkg::FLAG_SET_CLEAR: next_flags[`CPU_FLAG_C] = opcode_bit5; // SEC = 1
            default: result = op_b;                         // PASS
        endcase
        if (op != cpu_pkg::FLAG_SET_CLEAR) begin
            next_flags[`CPU_FLAG_N] = result[`CPU_DW-1];
            next_flags[`CPU_FLAG_Z] = (result == '0);
        end
    end

endmodule

// File: common/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------
    // Sequencer micro-states
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        FETCH,      // Opcode on DIN
        IMM,        // Immediate operand slot
        ZP,         // Zero page address byte
        ABS_LO,     // Absolute address, low byte
        ABS_HI,     // Absolute address, high byte
        EXEC,       // Commit cycle
        REL,        // Branch offset byte
        REL_PAGE,   // Extra cycle on page cross
        REL_DONE,   // Extra cycle on taken branch
        RST_LO,     // Point PC at the vector
        RST_HI,     // Vector low byte
        RST_JMP     // Vector high byte, jump
    } micro_state_t;

    typedef enum logic [2:0] {
        IMPLIED,
        IMMEDIATE,
        ZERO_PAGE,
        ABSOLUTE,
        RELATIVE,
        JUMP        // JMP absolute
    } addr_mode_t;

    // ------------------------------------------------------------
    // Datapath controls
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ORA,
        AND,
        EOR,
        ADC,
        PASS,           // Operand B straight through
        CMP,
        SBC,
        INC,
        DEC,
        FLAG_SET_CLEAR  // CLC and SEC
    } alu_op_t;

    typedef enum logic [1:0] {
        A,
        X,
        Y,
        MEM             // Data in from the bus
    } reg_sel_t;

endpackage

// File: common/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define CPU_DW 8                 // Data bus and register width
`define CPU_AW 16                // Address bus width

`define CPU_RESET_VECTOR 16'hFFFC // Low byte of reset vector

// ------------------------------------------------------------
// Bit positions in P
// ------------------------------------------------------------
`define CPU_FLAG_N 7             // Negative
`define CPU_FLAG_V 6             // Signed overflow
`define CPU_FLAG_Z 1             // Zero
`define CPU_FLAG_C 0             // Carry, not-borrow on subtract

`endif
